// File: hw/cell_state_store.sv
`timescale 1ns/1ps

`include "ew_defines.svh"

module cell_state_store
	import ew_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic i_ready,
	input  logic i_accept,
	input  row_t i_rd_row,
	input  logic i_wr_en,
	input  vec_t i_wr_data,
	output vec_t o_rd_data,
	output row_t o_wr_row,
	output logic o_hold
);

	localparam int LAST = `CS_PIPE_DEPTH - 1;

	vec_t mem [`CS_ROWS];

	store_state_t state;
	row_t clear_row;

	// Rows in flight, entry 0 is the newest.
	row_t tag_row [`CS_PIPE_DEPTH];
	logic [`CS_PIPE_DEPTH-1:0] tag_valid;

	logic row_busy;

	// Walk through every row once, then run.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CLEARING;
			clear_row <= '0;
		end else if (state == CLEARING) begin
			clear_row <= clear_row + 1'b1;
			if (clear_row == row_t'(`CS_ROWS - 1)) begin
				state <= RUNNING;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == CLEARING) begin
			mem[clear_row] <= '0;
		end else if (i_wr_en) begin
			mem[tag_row[LAST]] <= i_wr_data;
		end
	end

	// Tags move in step with the datapath stages.
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_valid <= '0;
		end else if (i_ready) begin
			tag_valid <= {tag_valid[LAST-1:0], i_accept};
		end
	end

	always_ff @(posedge clk) begin
		if (i_ready) begin
			tag_row[0] <= i_rd_row;
			for (int k = 1; k < `CS_PIPE_DEPTH; k++) begin
				tag_row[k] <= tag_row[k-1];
			end
		end
	end

	// A row still in flight has a stale value in the store.
	always_comb begin
		row_busy = 1'b0;
		for (int k = 0; k < `CS_PIPE_DEPTH; k++) begin
			if (tag_valid[k] && (tag_row[k] == i_rd_row)) begin
				row_busy = 1'b1;
			end
		end
	end

	assign o_hold = (state == CLEARING) | row_busy;
	assign o_rd_data = mem[i_rd_row];
	assign o_wr_row = tag_row[LAST];

endmodule

// File: hw/cell_state_update.sv
`timescale 1ns/1ps

`include "ew_defines.svh"

module cell_state_update
	import ew_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic i_valid,
	input  logic i_ready,
	input  row_t i_row,
	input  vec_t i_f,
	input  vec_t i_i,
	input  vec_t i_g,
	output logic o_valid,
	output logic o_ready,
	output row_t o_row,
	output vec_t o_c
);

	logic store_hold;
	logic accept;

	vec_t prev_c;

	vec_t fc_p;
	logic fc_valid;
	vec_t ig_p;
	logic ig_valid;

	vec_t new_c;
	logic add_valid;
	row_t wr_row;

	// Refused requests leave a bubble, the pipeline keeps moving.
	assign accept = i_valid & i_ready & ~store_hold;
	assign o_ready = i_ready & ~store_hold;

	cell_state_store u_store (
		.clk       (clk),
		.reset     (reset),
		.i_ready   (i_ready),
		.i_accept  (accept),
		.i_rd_row  (i_row),
		.i_wr_en   (add_valid),
		.i_wr_data (new_c),
		.o_rd_data (prev_c),
		.o_wr_row  (wr_row),
		.o_hold    (store_hold)
	);

	// Forget gate times the previous cell state.
	elementwise_mult_core u_mult_fc (
		.clk     (clk),
		.reset   (reset),
		.i_valid (accept),
		.i_ready (i_ready),
		.i_a     (i_f),
		.i_b     (prev_c),
		.o_p     (fc_p),
		.o_valid (fc_valid)
	);

	// Input gate times the candidate.
	elementwise_mult_core u_mult_ig (
		.clk     (clk),
		.reset   (reset),
		.i_valid (accept),
		.i_ready (i_ready),
		.i_a     (i_i),
		.i_b     (i_g),
		.o_p     (ig_p),
		.o_valid (ig_valid)
	);

	elementwise_add_core u_add (
		.clk     (clk),
		.reset   (reset),
		.i_valid (fc_valid & ig_valid),
		.i_ready (i_ready),
		.i_a     (fc_p),
		.i_b     (ig_p),
		.o_c     (new_c),
		.o_valid (add_valid),
		.o_ready ()
	);

	// The store's write row is the result's row.
	assign o_valid = add_valid;
	assign o_row = wr_row;
	assign o_c = new_c;

endmodule

// File: hw/elementwise_add_core.sv
`timescale 1ns/1ps

`include "ew_defines.svh"

module elementwise_add_core
	import ew_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic i_valid,
	input  logic i_ready,
	input  vec_t i_a,
	input  vec_t i_b,
	output vec_t o_c,
	output logic o_valid,
	output logic o_ready
);

	logic enable;

	vec_t reg_a;
	vec_t reg_b;
	vec_t reg_c;
	vec_t sum;

	logic valid_a_b;
	logic valid_c;

	// Whole pipeline stalls when downstream is not ready.
	assign enable = i_ready;

	// Lanewise sum, wrapping on overflow.
	always_comb begin
		lane_t lane_a;
		lane_t lane_b;
		sum = '0;
		for (int i = 0; i < `EW_LANES; i++) begin
			lane_a = reg_a[i*`EW_DATA_W +: `EW_DATA_W];
			lane_b = reg_b[i*`EW_DATA_W +: `EW_DATA_W];
			sum[i*`EW_DATA_W +: `EW_DATA_W] = lane_a + lane_b;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_a_b <= 1'b0;
			valid_c <= 1'b0;
		end else if (enable) begin
			valid_a_b <= i_valid;
			valid_c <= valid_a_b;
		end
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			reg_a <= i_a;
			reg_b <= i_b;
			reg_c <= sum;
		end
	end

	assign o_c = reg_c;
	assign o_valid = valid_c & i_ready;
	assign o_ready = i_ready;

endmodule

// File: hw/elementwise_mult_core.sv
`timescale 1ns/1ps

`include "ew_defines.svh"

module elementwise_mult_core
	import ew_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic i_valid,
	input  logic i_ready,
	input  vec_t i_a,
	input  vec_t i_b,
	output vec_t o_p,
	output logic o_valid
);

	// Largest and smallest lane values, widened to product width.
	localparam prod_t SAT_HI = {{(`EW_DATA_W+1){1'b0}}, {(`EW_DATA_W-1){1'b1}}};
	localparam prod_t SAT_LO = {{(`EW_DATA_W+1){1'b1}}, {(`EW_DATA_W-1){1'b0}}};

	// Half an output LSB, for round half up.
	localparam prod_t ROUND_HALF = prod_t'(1) <<< (`EW_FRAC_W - 1);

	logic enable;

	vec_t reg_a;
	vec_t reg_b;
	prod_t prod [`EW_LANES];
	prod_t reg_prod [`EW_LANES];
	vec_t scaled;
	vec_t reg_p;

	logic valid_a_b;
	logic valid_prod;
	logic valid_p;

	// Rescale a product back to lane format and clamp it.
	function automatic lane_t round_sat(input prod_t p);
		prod_t rounded;
		lane_t result;
		rounded = (p + ROUND_HALF) >>> `EW_FRAC_W;
		if (rounded > SAT_HI) begin
			result = SAT_HI[`EW_DATA_W-1:0];
		end else if (rounded < SAT_LO) begin
			result = SAT_LO[`EW_DATA_W-1:0];
		end else begin
			result = rounded[`EW_DATA_W-1:0];
		end
		return result;
	endfunction

	assign enable = i_ready;

	always_comb begin
		lane_t lane_a;
		lane_t lane_b;
		for (int i = 0; i < `EW_LANES; i++) begin
			lane_a = reg_a[i*`EW_DATA_W +: `EW_DATA_W];
			lane_b = reg_b[i*`EW_DATA_W +: `EW_DATA_W];
			prod[i] = prod_t'(lane_a) * prod_t'(lane_b);
		end
	end

	always_comb begin
		scaled = '0;
		for (int i = 0; i < `EW_LANES; i++) begin
			scaled[i*`EW_DATA_W +: `EW_DATA_W] = round_sat(reg_prod[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_a_b <= 1'b0;
			valid_prod <= 1'b0;
			valid_p <= 1'b0;
		end else if (enable) begin
			valid_a_b <= i_valid;
			valid_prod <= valid_a_b;
			valid_p <= valid_prod;
		end
	end

	// Operands, then full products, then the rounded result.
	always_ff @(posedge clk) begin
		if (enable) begin
			reg_a <= i_a;
			reg_b <= i_b;
			reg_prod <= prod;
			reg_p <= scaled;
		end
	end

	assign o_p = reg_p;
	assign o_valid = valid_p & i_ready;

endmodule

// File: hw/ew_defines.svh
`ifndef EW_DEFINES_SVH
`define EW_DEFINES_SVH

// Lanes carried side by side in one vector row.
`define EW_LANES 4

// Signed two's complement lane width.
`define EW_DATA_W 18

// Fraction bits of the fixed-point lane format.
`define EW_FRAC_W 10

// Full vector width, lane 0 in the low bits.
`define EW_VEC_W (`EW_LANES * `EW_DATA_W)

// Cell-state store geometry.
`define CS_ROWS 16
`define CS_ROW_W 4

// Three multiply stages followed by two add stages.
`define CS_PIPE_DEPTH 5

`endif

// File: hw/ew_pkg.sv
`include "ew_defines.svh"

package ew_pkg;

	// One fixed-point lane.
	typedef logic signed [`EW_DATA_W-1:0] lane_t;

	// A row of lanes, lane i at bits [i*EW_DATA_W +: EW_DATA_W].
	typedef logic [`EW_VEC_W-1:0] vec_t;

	// Full precision product of two lanes.
	typedef logic signed [2*`EW_DATA_W-1:0] prod_t;

	// Index into the cell-state store.
	typedef logic [`CS_ROW_W-1:0] row_t;

	// Store runs a clear pass once after reset.
	typedef enum logic {
		CLEARING,
		RUNNING
	} store_state_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cell-state update testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG='** FAIL **'

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator was not found in PATH"
	exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module cell_state_update_tb -Mdir "$BUILD_DIR"; then
	echo "Build failed"
	exit 1
fi

"./$BUILD_DIR/Vcell_state_update_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ "$sim_status" -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: sources.f
+incdir+hw
hw/ew_pkg.sv
hw/elementwise_add_core.sv
hw/elementwise_mult_core.sv
hw/cell_state_store.sv
hw/cell_state_update.sv
test/cell_state_update_checker.sv
test/cell_state_update_tb.sv

// File: test/cell_state_stimulus.txt
# row f0 f1 f2 f3 i0 i1 i2 i3 g0 g1 g2 g3 c0 c1 c2 c3, signed decimal lanes with 10 fraction bits
# c is the expected new cell state, every row starts from zero
0 1024 1024 1024 1024 1024 1024 1024 1024 100 -200 300 -400 100 -200 300 -400
1 512 512 512 512 1024 1024 1024 1024 1000 2000 -3000 4000 1000 2000 -3000 4000
2 0 0 0 0 2048 2048 2048 2048 65535 65536 -65536 -65537 131070 131071 -131072 -131072
3 1024 1024 1024 1024 512 512 512 512 1 2 3 -3 1 1 2 -1
4 1024 1024 1024 1024 1 1 -1 -1 511 512 512 513 0 1 0 -1
5 0 0 0 0 131071 -131072 -131072 131071 131071 131071 -131072 -131072 131071 -131072 131071 -131072
6 1024 1024 1024 1024 1024 1024 1024 1024 131071 -131072 5 0 131071 -131072 5 0
7 1024 1024 1024 1024 1536 1536 1536 1536 10 11 -10 -11 15 17 -15 -16
8 1024 1024 1024 1024 256 256 256 256 4 6 -4 -6 1 2 -1 -1
9 1024 1024 1024 1024 1024 1024 1024 1024 7 8 9 10 7 8 9 10
10 1024 1024 1024 1024 -1024 -1024 -1024 -1024 7 -8 0 131071 -7 8 0 -131071
11 1024 1024 1024 1024 1024 1024 1024 1024 1 2 3 4 1 2 3 4
12 1024 1024 1024 1024 1024 1024 1024 1024 50 60 70 80 50 60 70 80
13 1024 1024 1024 1024 1024 1024 1024 1024 -50 -60 -70 -80 -50 -60 -70 -80
14 1024 1024 1024 1024 1024 1024 1024 1024 1000 0 -1000 0 1000 0 -1000 0
15 1024 1024 1024 1024 2048 2048 2048 2048 1 2 3 4 2 4 6 8
0 1024 1024 1024 1024 1024 1024 1024 1024 1 1 1 1 101 -199 301 -399
0 512 512 512 512 1024 1024 1024 1024 0 0 0 0 51 -99 151 -199
6 1024 1024 1024 1024 1024 1024 1024 1024 1 -1 5 0 -131072 131071 10 0
6 1024 1024 1024 1024 0 0 0 0 0 0 0 0 -131072 131071 10 0
1 512 512 512 512 1024 1024 1024 1024 0 0 0 0 500 1000 -1500 2000
1 1024 1024 1024 1024 1024 1024 1024 1024 1 1 1 1 501 1001 -1499 2001
2 -1024 -1024 -1024 -1024 0 0 0 0 0 0 0 0 -131070 -131071 131071 131071
3 1024 1024 1024 1024 1024 1024 1024 1024 10 20 30 40 11 21 32 39
4 2048 2048 2048 2048 1024 1024 1024 1024 0 0 0 0 0 2 0 -2
4 1024 1024 1024 1024 1024 1024 1024 1024 3 3 3 3 3 5 3 1
5 1024 1024 1024 1024 0 0 0 0 0 0 0 0 131071 -131072 131071 -131072
7 0 0 0 0 1024 1024 1024 1024 1 2 3 4 1 2 3 4
8 1024 1024 1024 1024 1024 1024 1024 1024 100 100 100 100 101 102 99 99
9 1024 1024 1024 1024 512 512 512 512 3 3 3 3 9 10 11 12
10 1024 1024 1024 1024 1024 1024 1024 1024 -1 -1 -1 -2 -8 7 -1 131071
9 1024 1024 1024 1024 1024 1024 1024 1024 1 1 1 1 10 11 12 13
11 3072 3072 3072 3072 0 0 0 0 0 0 0 0 3 6 9 12
12 1024 1024 1024 1024 1024 1024 1024 1024 -50 -60 -70 -80 0 0 0 0
13 -1024 -1024 -1024 -1024 0 0 0 0 0 0 0 0 50 60 70 80
14 1024 1024 1024 1024 1024 1024 1024 1024 24 1 24 1 1024 1 -976 1
15 1024 1024 1024 1024 1024 1024 1024 1024 1 1 1 1 3 5 7 9
0 1024 1024 1024 1024 1024 1024 1024 1024 -51 99 -151 199 0 0 0 0

// File: test/cell_state_update_checker.sv
`timescale 1ns/1ps

`include "ew_defines.svh"

module cell_state_update_checker
	import ew_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic i_ready,
	input logic i_out_valid,
	input logic i_out_ready,
	input store_state_t i_store_state
);

	// Outputs stay low once reset has been seen on an earlier edge.
	reset_quiet: assert property (@(posedge clk)
		(reset && $past(reset)) |-> (!i_out_valid && !i_out_ready))
		else $error("o_valid or o_ready high during reset");

	no_valid_in_stall: assert property (@(posedge clk) disable iff (reset)
		i_out_valid |-> i_ready)
		else $error("o_valid high while i_ready is low");

	// Upstream is held off until every row is zeroed.
	no_ready_clearing: assert property (@(posedge clk) disable iff (reset)
		(i_store_state == CLEARING) |-> !i_out_ready)
		else $error("o_ready high while the store is clearing");

endmodule

bind cell_state_update cell_state_update_checker u_checker (
	.clk           (clk),
	.reset         (reset),
	.i_ready       (i_ready),
	.i_out_valid   (o_valid),
	.i_out_ready   (o_ready),
	.i_store_state (u_store.state)
);

// File: test/cell_state_update_tb.sv
`timescale 1ns/1ps

`include "ew_defines.svh"

module cell_state_update_tb
	import ew_pkg::*;
();

	localparam string STIM_FILE = "test/cell_state_stimulus.txt";
	localparam int FIELDS = 1 + 4 * `EW_LANES;

	logic clk = 1'b0;
	logic reset;
	logic i_valid;
	logic i_ready;
	row_t i_row;
	vec_t i_f;
	vec_t i_i;
	vec_t i_g;
	logic o_valid;
	logic o_ready;
	row_t o_row;
	vec_t o_c;

	row_t stim_row [$];
	vec_t stim_f [$];
	vec_t stim_i [$];
	vec_t stim_g [$];
	vec_t stim_c [$];

	// Line index and enabled edge count of each accepted update.
	int pend_idx [$];
	int pend_edge [$];

	int n_lines = 0;
	int accepted = 0;
	int checked = 0;
	int enabled_edges = 0;
	int clear_cycles = 0;
	logic cleared = 1'b0;
	int seed = 98886;

	always #5 clk = ~clk;

	cell_state_update dut (
		.clk     (clk),
		.reset   (reset),
		.i_valid (i_valid),
		.i_ready (i_ready),
		.i_row   (i_row),
		.i_f     (i_f),
		.i_i     (i_i),
		.i_g     (i_g),
		.o_valid (o_valid),
		.o_ready (o_ready),
		.o_row   (o_row),
		.o_c     (o_c)
	);

	function automatic vec_t pack_vec(input int v [FIELDS], input int first);
		vec_t vec;
		vec = '0;
		for (int k = 0; k < `EW_LANES; k++) begin
			vec[k*`EW_DATA_W +: `EW_DATA_W] = v[first + k][`EW_DATA_W-1:0];
		end
		return vec;
	endfunction

	function automatic lane_t lane_of(input vec_t v, input int k);
		return v[k*`EW_DATA_W +: `EW_DATA_W];
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic signed [31:0] expected,
			input logic signed [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail at %0t: %s expected %0d, got %0d",
				$time, name, expected, actual));
		end
	endtask

	initial begin
		int fd;
		int fields;
		int idx;
		int v [FIELDS];
		logic [8*256-1:0] text;
		reset = 1'b1;
		i_valid = 1'b0;
		i_ready = 1'b1;
		i_row = '0;
		i_f = '0;
		i_i = '0;
		i_g = '0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			abort_run("Cannot open the stimulus file");
		end
		// Comment and blank lines scan no numbers and are skipped.
		while ($fgets(text, fd) != 0) begin
			fields = $sscanf(text, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
				v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
			if (fields == FIELDS) begin
				stim_row.push_back(row_t'(v[0]));
				stim_f.push_back(pack_vec(v, 1));
				stim_i.push_back(pack_vec(v, 1 + `EW_LANES));
				stim_g.push_back(pack_vec(v, 1 + 2 * `EW_LANES));
				stim_c.push_back(pack_vec(v, 1 + 3 * `EW_LANES));
			end else if (fields > 0) begin
				abort_run("A line of the stimulus file has the wrong number of fields");
			end
		end
		$fclose(fd);
		if (stim_row.size() == 0) begin
			abort_run("The stimulus file holds no updates");
		end
		n_lines = stim_row.size();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		idx = 0;
		while (idx < n_lines) begin
			i_valid = 1'b1;
			i_row = stim_row[idx];
			i_f = stim_f[idx];
			i_i = stim_i[idx];
			i_g = stim_g[idx];
			@(negedge clk);
			if (i_valid && o_ready) begin
				idx++;
			end
			@(posedge clk);
			#1;
			// Back-pressure only in the second half of the file.
			if (idx < n_lines / 2) begin
				i_ready = 1'b1;
			end else begin
				i_ready = (($random(seed) & 3) != 0);
			end
		end
		i_valid = 1'b0;
		i_ready = 1'b1;
		wait (checked == n_lines);
		repeat (10) @(posedge clk);
		$display("** PASS **");
		$finish;
	end

	// Inputs and outputs are settled by the falling edge.
	always @(negedge clk) begin
		int idx;
		int latency;
		if (!reset) begin
			// Upstream is held off while the store zeroes its rows.
			if (!cleared) begin
				if (o_ready) begin
					check_value("o_ready low cycles after reset", `CS_ROWS, clear_cycles);
					cleared = 1'b1;
				end else begin
					clear_cycles++;
				end
			end
			if (o_valid && !i_ready) begin
				abort_run("o_valid was high while i_ready was low");
			end
			if (o_valid) begin
				if (pend_idx.size() == 0) begin
					abort_run("A result arrived with no update pending");
				end
				idx = pend_idx.pop_front();
				latency = enabled_edges - pend_edge.pop_front();
				check_value("latency", `CS_PIPE_DEPTH, latency);
				check_value("o_row", stim_row[idx], o_row);
				for (int k = 0; k < `EW_LANES; k++) begin
					check_value($sformatf("o_c lane %0d", k), lane_of(stim_c[idx], k),
						lane_of(o_c, k));
				end
				checked++;
			end
			if (i_valid && o_ready) begin
				pend_idx.push_back(accepted);
				pend_edge.push_back(enabled_edges);
				accepted++;
			end
			if (i_ready) begin
				enabled_edges++;
			end
		end
	end

	initial begin
		wait (n_lines > 0);
		repeat (n_lines * 20 + 200) @(posedge clk);
		$display("Timeout: results stopped arriving, %0d of %0d checked", checked, n_lines);
		$display("** FAIL **");
		$fatal(1, "Watchdog expired");
	end

endmodule
